// File: src/rename_pkg.sv
package rename_pkg;

  localparam int num_arch_regs = 32;
  localparam int num_phys_regs = 64;
  localparam int arch_w = 5;
  localparam int phys_w = 6;
  localparam int data_w = 64;
  localparam int imm_w = 16;

  typedef logic [arch_w-1:0] arch_reg_t;
  typedef logic [phys_w-1:0] phys_reg_t;

  // reg-reg form, padded out to the reg-imm width
  typedef struct packed {
    arch_reg_t dst;
    arch_reg_t src1;
    arch_reg_t src2;
    logic [10:0] pad;
  } uop_rr_t;

  typedef struct packed {
    arch_reg_t dst;
    arch_reg_t src;
    logic [imm_w-1:0] imm;
  } uop_ri_t;

  // same payload word, decoded by valb_sel
  typedef union packed {
    uop_rr_t rr;
    uop_ri_t ri;
  } uop_data_u;

  typedef struct packed {
    logic [31:0] pc;
    logic valb_sel;  // 1 = reg-reg
    uop_data_u data;
  } uop_t;

  typedef struct packed {
    logic [31:0] pc;
    uop_t uop;
    phys_reg_t src1_phys;
    phys_reg_t src2_phys;
    phys_reg_t dest_phys;
    phys_reg_t prev_dest_phys;  // freed when this entry commits
  } rob_entry_t;

  typedef struct packed {
    logic en;
    phys_reg_t index;
    logic [data_w-1:0] data;
  } prf_wr_t;

  typedef struct packed {
    logic [1:0] valid;
    phys_reg_t [1:0] tag;
  } commit_t;

endpackage

// File: src/free_list.sv
module free_list import rename_pkg::*; (
  input logic clk,
  input logic rst,
  input logic [2:0] pop_cnt,
  input commit_t commit,
  output phys_reg_t [3:0] free_tags,
  output logic [6:0] free_count
);

  // depth equals the tag space, so pointers wrap naturally at phys_w bits
  phys_reg_t queue [num_phys_regs];
  phys_reg_t head;
  phys_reg_t tail;
  logic [1:0] push_cnt;

  assign push_cnt = 2'(commit.valid[0]) + 2'(commit.valid[1]);

  always_comb begin
    for (int k = 0; k < 4; k++) begin
      free_tags[k] = queue[head + phys_reg_t'(k)];  // next four in order
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      head <= '0;
      tail <= phys_reg_t'(num_phys_regs - num_arch_regs);
      free_count <= 7'(num_phys_regs - num_arch_regs);
      // tags above the identity map start out free
      for (int i = 0; i < num_phys_regs - num_arch_regs; i++) begin
        queue[i] <= phys_reg_t'(num_arch_regs + i);
      end
    end else begin
      head <= head + phys_reg_t'(pop_cnt);
      tail <= tail + phys_reg_t'(push_cnt);
      free_count <= free_count + 7'(push_cnt) - 7'(pop_cnt);
      if (commit.valid[0]) begin
        queue[tail] <= commit.tag[0];
      end
      if (commit.valid[1]) begin
        queue[tail + phys_reg_t'(commit.valid[0])] <= commit.tag[1];  // after lane 0
      end
    end
  end

  no_overflow: assert property (@(posedge clk) disable iff (!rst)
    8'(free_count) + 8'(push_cnt) - 8'(pop_cnt) <= 8'(num_phys_regs));

  no_underflow: assert property (@(posedge clk) disable iff (!rst)
    7'(pop_cnt) <= free_count);

endmodule

// File: src/rat.sv
module rat import rename_pkg::*; (
  input logic clk,
  input logic rst,
  input logic in_valid,
  input uop_t [1:0] instr,
  output logic in_ready,
  output rob_entry_t [1:0] rob_data,
  output logic rob_valid,
  input logic rob_ready,
  input phys_reg_t [3:0] free_tags,
  input logic [6:0] free_count,
  output logic [2:0] pop_cnt,
  output prf_wr_t [1:0] imm_req,
  input logic [1:0] imm_gnt
);

  phys_reg_t map [num_arch_regs];
  logic live;  // high once out of reset
  logic accept;
  logic imm_pending;
  logic [2:0] need;
  arch_reg_t [1:0] dst;
  arch_reg_t [1:0] src1;
  arch_reg_t [1:0] src2;
  phys_reg_t [1:0] extra;
  phys_reg_t [1:0] src1_phys;
  phys_reg_t [1:0] src2_phys;
  phys_reg_t [1:0] prev_phys;

  // two destinations always, plus one per reg-imm lane
  assign need = 3'd2 + 3'(!instr[0].valb_sel) + 3'(!instr[1].valb_sel);
  assign imm_pending = imm_req[0].en || imm_req[1].en;
  assign in_ready = live && (!rob_valid || rob_ready) && !imm_pending
                    && (free_count >= 7'(need));
  assign accept = in_valid && in_ready;
  assign pop_cnt = accept ? need : 3'd0;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      // dst and first source sit at the same bits in both forms
      dst[i] = instr[i].data.rr.dst;
      src1[i] = instr[i].data.rr.src1;
      src2[i] = instr[i].data.rr.src2;  // only meaningful for reg-reg
    end

    // extra tags handed out in lane order after the two destinations
    extra[0] = free_tags[2];
    extra[1] = instr[0].valb_sel ? free_tags[2] : free_tags[3];

    src1_phys[0] = map[src1[0]];
    src2_phys[0] = instr[0].valb_sel ? map[src2[0]] : extra[0];
    prev_phys[0] = map[dst[0]];

    // lane 1 sees lane 0's new destination
    src1_phys[1] = (src1[1] == dst[0]) ? free_tags[0] : map[src1[1]];
    if (!instr[1].valb_sel) begin
      src2_phys[1] = extra[1];
    end else if (src2[1] == dst[0]) begin
      src2_phys[1] = free_tags[0];
    end else begin
      src2_phys[1] = map[src2[1]];
    end
    prev_phys[1] = (dst[1] == dst[0]) ? free_tags[0] : map[dst[1]];
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      live <= 1'b0;
      rob_valid <= 1'b0;
      imm_req <= '0;
      for (int i = 0; i < num_arch_regs; i++) begin
        map[i] <= phys_reg_t'(i);  // identity
      end
    end else begin
      live <= 1'b1;
      if (accept) begin
        rob_valid <= 1'b1;
        map[dst[0]] <= free_tags[0];
        map[dst[1]] <= free_tags[1];  // lane 1 wins on same dst
      end else if (rob_ready) begin
        rob_valid <= 1'b0;
      end
      for (int i = 0; i < 2; i++) begin
        if (accept) begin
          imm_req[i].en <= !instr[i].valb_sel;
          imm_req[i].index <= extra[i];
          imm_req[i].data <= {{(data_w - imm_w){1'b0}}, instr[i].data.ri.imm};
        end else if (imm_gnt[i]) begin
          imm_req[i].en <= 1'b0;  // drop after grant
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      for (int i = 0; i < 2; i++) begin
        rob_data[i].pc <= instr[i].pc;
        rob_data[i].uop <= instr[i];
        rob_data[i].src1_phys <= src1_phys[i];
        rob_data[i].src2_phys <= src2_phys[i];
        rob_data[i].dest_phys <= free_tags[i];
        rob_data[i].prev_dest_phys <= prev_phys[i];
      end
    end
  end

  pop_within_free: assert property (@(posedge clk) disable iff (!rst)
    7'(pop_cnt) <= free_count);

  imm0_held: assert property (@(posedge clk) disable iff (!rst)
    imm_req[0].en && !imm_gnt[0] |=> $stable(imm_req[0]));

  imm1_held: assert property (@(posedge clk) disable iff (!rst)
    imm_req[1].en && !imm_gnt[1] |=> $stable(imm_req[1]));

endmodule

// File: src/prf_write_arb.sv
module prf_write_arb import rename_pkg::*; (
  input logic clk,
  input logic rst,
  input prf_wr_t wb_req,
  input prf_wr_t [1:0] imm_req,
  output logic [1:0] imm_gnt,
  output prf_wr_t wr
);

  // writeback never waits, then lane 0, then lane 1
  always_comb begin
    imm_gnt[0] = imm_req[0].en && !wb_req.en;
    imm_gnt[1] = imm_req[1].en && !wb_req.en && !imm_req[0].en;
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      wr <= '0;
    end else begin
      if (wb_req.en) begin
        wr <= wb_req;
      end else if (imm_gnt[0]) begin
        wr <= imm_req[0];
      end else if (imm_gnt[1]) begin
        wr <= imm_req[1];
      end else begin
        wr.en <= 1'b0;  // idle, payload don't care
      end
    end
  end

  // single write port, so writeback and lane grants exclude each other
  one_grant: assert property (@(posedge clk) disable iff (!rst)
    $onehot0({wb_req.en, imm_gnt}));

endmodule

// File: src/phys_regfile.sv
module phys_regfile import rename_pkg::*; (
  input logic clk,
  input logic rst,
  input prf_wr_t wr,
  input phys_reg_t [1:0] rd_addr,
  output logic [1:0][data_w-1:0] rd_data
);

  logic [data_w-1:0] mem [num_phys_regs];

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < num_phys_regs; i++) begin
        mem[i] <= '0;
      end
    end else if (wr.en) begin
      mem[wr.index] <= wr.data;
    end
  end

  // write-through so a registered write is readable in its own cycle
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      if (wr.en && (wr.index == rd_addr[i])) begin
        rd_data[i] = wr.data;
      end else begin
        rd_data[i] = mem[rd_addr[i]];
      end
    end
  end

endmodule

// File: src/rename_top.sv
module rename_top import rename_pkg::*; (
  input logic clk,
  input logic rst,
  input logic in_valid,
  input uop_t [1:0] instr,
  output logic in_ready,
  output rob_entry_t [1:0] rob_data,
  output logic rob_valid,
  input logic rob_ready,
  input prf_wr_t wb_req,
  input commit_t commit,
  output logic wb_busy,
  input phys_reg_t [1:0] rd_addr,
  output logic [1:0][data_w-1:0] rd_data
);

  phys_reg_t [3:0] free_tags;
  logic [6:0] free_count;
  logic [2:0] pop_cnt;
  prf_wr_t [1:0] imm_req;
  logic [1:0] imm_gnt;
  prf_wr_t prf_wr;

  assign wb_busy = imm_req[0].en || imm_req[1].en;  // immediates still in flight

  rat i_rat (
    .clk, .rst, .in_valid, .instr, .in_ready, .rob_data, .rob_valid, .rob_ready,
    .free_tags, .free_count, .pop_cnt, .imm_req, .imm_gnt
  );

  free_list i_free_list (
    .clk, .rst, .pop_cnt, .commit, .free_tags, .free_count
  );

  prf_write_arb i_prf_write_arb (
    .clk, .rst, .wb_req, .imm_req, .imm_gnt, .wr(prf_wr)
  );

  phys_regfile i_phys_regfile (
    .clk, .rst, .wr(prf_wr), .rd_addr, .rd_data
  );

endmodule

// File: verification/rename_model.sv
module rename_model import rename_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  phys_reg_t map [num_arch_regs];
  phys_reg_t free_q [$];  // head is the next tag handed out
  logic [data_w-1:0] regs [num_phys_regs];

  task automatic reset_state();
    free_q.delete();
    for (int i = 0; i < num_arch_regs; i++) begin
      map[i] = phys_reg_t'(i);
    end
    for (int i = num_arch_regs; i < num_phys_regs; i++) begin
      free_q.push_back(phys_reg_t'(i));
    end
    for (int i = 0; i < num_phys_regs; i++) begin
      regs[i] = '0;
    end
  endtask

  // two destinations plus one extra per reg-imm lane
  function automatic int needed(uop_t [1:0] b);
    return 2 + int'(!b[0].valb_sel) + int'(!b[1].valb_sel);
  endfunction

  function automatic int free_size();
    return free_q.size();
  endfunction

  function automatic phys_reg_t free_at(int k);
    return free_q[k];
  endfunction

  function automatic logic [data_w-1:0] read_reg(phys_reg_t idx);
    return regs[idx];
  endfunction

  task automatic write_reg(phys_reg_t idx, logic [data_w-1:0] d);
    regs[idx] = d;
  endtask

  task automatic push_free(phys_reg_t t);
    free_q.push_back(t);
  endtask

  // lanes applied one after the other, so lane 1 sees lane 0's new mapping
  task automatic rename_bundle(input uop_t [1:0] b, output rob_entry_t [1:0] e);
    int next;
    arch_reg_t d;
    next = 2;
    for (int i = 0; i < 2; i++) begin
      e[i].pc = b[i].pc;
      e[i].uop = b[i];
      e[i].dest_phys = free_q[i];
      if (b[i].valb_sel) begin
        d = b[i].data.rr.dst;
        e[i].src1_phys = map[b[i].data.rr.src1];
        e[i].src2_phys = map[b[i].data.rr.src2];
      end else begin
        d = b[i].data.ri.dst;
        e[i].src1_phys = map[b[i].data.ri.src];
        e[i].src2_phys = free_q[next];  // extra tag carries the immediate
        next++;
      end
      e[i].prev_dest_phys = map[d];
      map[d] = free_q[i];
    end
    repeat (next) begin
      void'(free_q.pop_front());
    end
  endtask

endmodule

// File: verification/rename_tb.sv
module rename_tb import rename_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_bundles = 200;
  localparam int clk_period = 4;

  logic clk;
  logic rst;
  logic in_valid;
  logic in_ready;
  logic rob_valid;
  logic rob_ready;
  logic wb_busy;
  uop_t [1:0] instr;
  rob_entry_t [1:0] rob_data;
  prf_wr_t wb_req;
  commit_t commit;
  phys_reg_t [1:0] rd_addr;
  logic [1:0][data_w-1:0] rd_data;

  rename_top i_rename_top (.*);
  rename_model model ();

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(num_bundles * 20 * clk_period);
    $display("Watchdog expired at %0t before all bundles were renamed", $time);
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

  task automatic compare(string name, logic [127:0] got, logic [127:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  function automatic uop_t random_uop();
    uop_t u;
    u.pc = $urandom;
    u.valb_sel = 1'($urandom);
    u.data.ri.dst = arch_reg_t'($urandom_range(7, 0));  // few regs, more lane overlap
    u.data.ri.src = arch_reg_t'($urandom_range(7, 0));
    u.data.ri.imm = 16'($urandom);
    return u;
  endfunction

  initial begin
    rob_entry_t [1:0] exp_rob;
    rob_entry_t [1:0] e;
    prf_wr_t [1:0] exp_imm;
    logic [1:0] pending;  // immediate writes not yet granted
    logic exp_valid;
    logic go;
    logic taken;
    commit_t c;
    phys_reg_t watch_tag;
    phys_reg_t done_q [$];  // tags waiting to be committed
    int accepted;
    void'($urandom(3));
    rst = 1'b0;
    in_valid = 1'b0;
    instr = '0;
    rob_ready = 1'b0;
    wb_req = '0;
    commit = '0;
    rd_addr = '0;
    pending = '0;
    exp_valid = 1'b0;
    watch_tag = '0;
    accepted = 0;
    model.reset_state();
    repeat (8) @(posedge clk);
    rst <= 1'b1;
    repeat (2) @(posedge clk);
    // keep going until the last entry and its immediates have been seen
    while (accepted < num_bundles || exp_valid || (|pending)) begin
      @(negedge clk);
      compare("rob_valid", rob_valid, exp_valid);
      if (exp_valid) begin
        compare("rob_data[0]", rob_data[0], exp_rob[0]);
        compare("rob_data[1]", rob_data[1], exp_rob[1]);
      end
      compare("wb_busy", wb_busy, |pending);
      for (int i = 0; i < 2; i++) begin
        compare($sformatf("rd_data[%0d]", i), rd_data[i], model.read_reg(rd_addr[i]));
      end
      go = (!exp_valid || rob_ready) && !(|pending)
           && (model.free_size() >= model.needed(instr));
      compare("in_ready", in_ready, go);
      taken = in_valid && go;
      // single write port, writeback first
      if (wb_req.en) begin
        model.write_reg(wb_req.index, wb_req.data);
      end else if (pending[0]) begin
        model.write_reg(exp_imm[0].index, exp_imm[0].data);
        pending[0] = 1'b0;
      end else if (pending[1]) begin
        model.write_reg(exp_imm[1].index, exp_imm[1].data);
        pending[1] = 1'b0;
      end
      if (taken) begin
        model.rename_bundle(instr, e);
        exp_rob = e;
        exp_valid = 1'b1;
        accepted++;
        for (int i = 0; i < 2; i++) begin
          pending[i] = !instr[i].valb_sel;
          exp_imm[i] = {1'b1, e[i].src2_phys, {(data_w - imm_w){1'b0}}, instr[i].data.ri.imm};
          done_q.push_back(e[i].prev_dest_phys);
          if (!instr[i].valb_sel) begin
            done_q.push_back(e[i].src2_phys);
            watch_tag = e[i].src2_phys;
          end
        end
      end else if (rob_ready) begin
        exp_valid = 1'b0;
      end
      for (int i = 0; i < 2; i++) begin
        if (commit.valid[i]) model.push_free(commit.tag[i]);  // lane 0 first
      end
      @(posedge clk);
      if (!in_valid || taken) begin
        in_valid <= (accepted < num_bundles) && ($urandom_range(3, 0) != 0);
        instr <= {random_uop(), random_uop()};
      end
      rob_ready <= ($urandom_range(3, 0) != 0);
      rd_addr <= {wb_req.index, ($urandom_range(1, 0) != 0) ? watch_tag : phys_reg_t'($urandom)};
      wb_req.en <= ($urandom_range(2, 0) == 0) && (model.free_size() > 0);
      if (model.free_size() > 0) begin
        wb_req.index <= model.free_at(int'($urandom % model.free_size()));
      end
      wb_req.data <= {$urandom, $urandom};
      c = '0;
      for (int i = 0; i < 2; i++) begin
        if (done_q.size() > 0 && $urandom_range(2, 0) == 0) begin
          c.valid[i] = 1'b1;
          c.tag[i] = done_q.pop_front();
        end
      end
      commit <= c;
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: rename_top.f
src/rename_pkg.sv
src/free_list.sv
src/rat.sv
src/prf_write_arb.sv
src/phys_regfile.sv
src/rename_top.sv
verification/rename_model.sv
verification/rename_tb.sv

// File: Bender.yml
package:
  name: rename_top

sources:
  - src/rename_pkg.sv
  - src/free_list.sv
  - src/rat.sv
  - src/prf_write_arb.sv
  - src/phys_regfile.sv
  - src/rename_top.sv
  - target: test
    files:
      - verification/rename_model.sv
      - verification/rename_tb.sv
